//--- all.f
+incdir+rtl
rtl/apb_pkg.sv
rtl/apb_master.sv
rtl/apb_reg_slave.sv
rtl/apb_monitor.sv
rtl/apb_subsystem.sv
bench/tb_apb_subsystem.sv

//--- bench/tb_apb_subsystem.sv
// Self-checking testbench for the APB subsystem
// Drives host commands and predicts responses with a register model of both slaves
// Checks data, error flag, latency, cmd_ready and the monitor counters

`timescale 1ns/100ps

`include "apb_config.svh"

module tb_apb_subsystem;

  localparam int CLK_PERIOD = 40;
  localparam int RAND_ITERS = 40;
  // Full-word pass, random pairs, range/prot, decode misses, final sweep
  localparam int NUM_CMDS   = 2 * `APB_SLAVE_COUNT * `APB_REG_COUNT + 2 * RAND_ITERS
                              + 12 + 6 + `APB_SLAVE_COUNT * `APB_REG_COUNT;
  localparam int MAX_WS     = (`APB_WAIT_STATES_0 > `APB_WAIT_STATES_1) ?
                              `APB_WAIT_STATES_0 : `APB_WAIT_STATES_1;
  localparam int LIMIT_CYC  = NUM_CMDS * (3 + MAX_WS + 4) + 5;

  logic        pclk;
  logic        rst_n;
  logic        cmd_valid;
  logic        cmd_write;
  logic [15:0] cmd_addr;
  logic [31:0] cmd_wdata;
  logic [3:0]  cmd_strb;
  logic [2:0]  cmd_prot;
  logic        cmd_ready;
  logic        rsp_valid;
  logic [31:0] rsp_rdata;
  logic        rsp_err;
  logic [15:0] xfer_count;
  logic [15:0] err_count;

  // Register model and expected monitor counts
  logic [31:0] model_regs [`APB_SLAVE_COUNT][`APB_REG_COUNT];
  int          exp_xfers;
  int          exp_errs;

  // Outstanding expectations with one entry per command
  string       name_q [$];
  logic [31:0] data_q [$];
  logic        err_q [$];
  int          lat_q [$];

  logic [31:0] rng_state;
  int          cyc;
  int          acc_cyc;
  bit          in_flight;
  int          cmd_count;
  int          rsp_count;
  int          checks;
  int          errors;

  apb_subsystem i_apb_subsystem (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_write  (cmd_write),
    .cmd_addr   (cmd_addr),
    .cmd_wdata  (cmd_wdata),
    .cmd_strb   (cmd_strb),
    .cmd_prot   (cmd_prot),
    .cmd_ready  (cmd_ready),
    .rsp_valid  (rsp_valid),
    .rsp_rdata  (rsp_rdata),
    .rsp_err    (rsp_err),
    .xfer_count (xfer_count),
    .err_count  (err_count)
  );

  always #(CLK_PERIOD / 2) pclk = ~pclk;

  // Edge counter for latency measurement
  always @(posedge pclk) cyc <= cyc + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Packs slave field, register index and byte offset
  function automatic logic [15:0] make_addr(input int slave, input int idx, input int off);
    logic [15:0] a;
    a = {slave[10:0], idx[2:0], off[1:0]};
    return a;
  endfunction

  // Expected response of one command
  // Accepted writes update the model
  function automatic void model_access(input logic wr, input logic [15:0] addr,
                                       input logic [31:0] wdata, input logic [3:0] strb,
                                       input logic [2:0] prot, output logic [31:0] rdata,
                                       output logic err, output int lat);
    int s;
    int r;
    int b;
    s     = int'(addr[15:5]);
    r     = int'(addr[4:2]);
    rdata = '0;
    err   = 1'b0;
    if (s >= `APB_SLAVE_COUNT) begin
      // Decode miss never reaches the bus
      err = 1'b1;
      lat = 1;
    end else begin
      lat = 3 + ((s == 0) ? `APB_WAIT_STATES_0 : `APB_WAIT_STATES_1);
      exp_xfers++;
      if (r >= `APB_REG_COUNT) begin
        err = 1'b1;
      end else if (wr && r == 0 && !prot[0]) begin
        err = 1'b1;
      end else if (wr) begin
        for (b = 0; b < 4; b++) begin
          if (strb[b]) model_regs[s][r][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end else begin
        rdata = model_regs[s][r];
      end
      if (err) exp_errs++;
    end
  endfunction

  // One command pulse once the master is idle
  task automatic issue(input string name, input logic wr, input logic [15:0] addr,
                       input logic [31:0] wdata, input logic [3:0] strb,
                       input logic [2:0] prot);
    logic [31:0] exp_data;
    logic        exp_err;
    int          exp_lat;
    @(negedge pclk);
    while (!cmd_ready) @(negedge pclk);
    model_access(wr, addr, wdata, strb, prot, exp_data, exp_err, exp_lat);
    name_q.push_back(name);
    data_q.push_back(exp_data);
    err_q.push_back(exp_err);
    lat_q.push_back(exp_lat);
    cmd_count++;
    @(posedge pclk);
    cmd_valid <= 1'b1;
    cmd_write <= wr;
    cmd_addr  <= addr;
    cmd_wdata <= wdata;
    cmd_strb  <= strb;
    cmd_prot  <= prot;
    @(posedge pclk);
    cmd_valid <= 1'b0;
  endtask

  // Compare process sampling on the falling edge
  always @(negedge pclk) begin
    string       nm;
    logic [31:0] ed;
    logic        ee;
    int          el;
    if (rst_n) begin
      if (in_flight) begin
        checks++;
        assert (!cmd_ready) else begin
          errors++;
          $display("cmd_ready went high in the middle of a transfer at cycle %0d", cyc);
        end
      end
      if (rsp_valid) begin
        checks++;
        assert (name_q.size() != 0) else begin
          errors++;
          $display("Response arrived with no command outstanding at cycle %0d", cyc);
        end
        if (name_q.size() != 0) begin
          nm = name_q.pop_front();
          ed = data_q.pop_front();
          ee = err_q.pop_front();
          el = lat_q.pop_front();
          checks += 3;
          assert (rsp_rdata == ed) else begin
            errors++;
            $display("Error %s rdata expected %h actual %h", nm, ed, rsp_rdata);
          end
          assert (rsp_err == ee) else begin
            errors++;
            $display("Error %s err expected %0b actual %0b", nm, ee, rsp_err);
          end
          assert (cyc - acc_cyc == el) else begin
            errors++;
            $display("Error %s latency expected %0d actual %0d", nm, el, cyc - acc_cyc);
          end
        end
        in_flight = 1'b0;
        rsp_count++;
      end
      // Accept happens on the next rising edge
      if (cmd_valid && cmd_ready) begin
        acc_cyc   = cyc;
        in_flight = 1'b1;
      end
    end
  end

  // Watchdog sized from the command count
  initial begin
    #(LIMIT_CYC * CLK_PERIOD);
    $display("Run timed out after %0d cycles, %0d of %0d responses seen",
             LIMIT_CYC, rsp_count, cmd_count);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] wdata;
    int          s;
    int          r;
    pclk      = 1'b0;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_write = 1'b0;
    cmd_addr  = '0;
    cmd_wdata = '0;
    cmd_strb  = '0;
    cmd_prot  = '0;
    rng_state = 32'd84;
    cyc       = 0;
    in_flight = 1'b0;
    exp_xfers = 0;
    exp_errs  = 0;
    for (s = 0; s < `APB_SLAVE_COUNT; s++) begin
      for (r = 0; r < `APB_REG_COUNT; r++) model_regs[s][r] = '0;
    end
    repeat (5) @(posedge pclk);
    rst_n <= 1'b1;

    // Privileged full-word writes on every implemented register
    for (s = 0; s < `APB_SLAVE_COUNT; s++) begin
      for (r = 0; r < `APB_REG_COUNT; r++) begin
        wdata = draw();
        issue($sformatf("full_s%0d_r%0d_wr", s, r), 1'b1, make_addr(s, r, 0), wdata, 4'hf, 3'b001);
        issue($sformatf("full_s%0d_r%0d_rd", s, r), 1'b0, make_addr(s, r, 0), '0, 4'hf, 3'b001);
      end
    end

    // Random strobes, prot and index with each write read back
    for (int i = 0; i < RAND_ITERS; i++) begin
      rnd   = draw();
      wdata = draw();
      s     = int'(rnd[0]);
      r     = int'(rnd[3:1]);
      issue($sformatf("rand_%0d_wr", i), 1'b1, make_addr(s, r, int'(rnd[5:4])), wdata,
            rnd[9:6], rnd[12:10]);
      issue($sformatf("rand_%0d_rd", i), 1'b0, make_addr(s, r, 0), '0, 4'hf, rnd[15:13]);
    end

    // Unimplemented slots and unprivileged writes to register 0
    for (s = 0; s < `APB_SLAVE_COUNT; s++) begin
      for (r = 6; r < 8; r++) begin
        issue($sformatf("range_s%0d_r%0d_wr", s, r), 1'b1, make_addr(s, r, 0), draw(),
              4'hf, 3'b001);
        issue($sformatf("range_s%0d_r%0d_rd", s, r), 1'b0, make_addr(s, r, 0), '0, 4'hf, 3'b001);
      end
      issue($sformatf("prot_s%0d_wr", s), 1'b1, make_addr(s, 0, 0), draw(), 4'hf, 3'b000);
      issue($sformatf("prot_s%0d_rd", s), 1'b0, make_addr(s, 0, 0), '0, 4'hf, 3'b000);
    end

    // Slave fields with no slave behind them
    issue("dec_2_wr", 1'b1, make_addr(2, 1, 0), draw(), 4'hf, 3'b001);
    issue("dec_2_rd", 1'b0, make_addr(2, 1, 0), '0, 4'hf, 3'b001);
    issue("dec_3_wr", 1'b1, make_addr(3, 0, 0), draw(), 4'hf, 3'b001);
    issue("dec_3_rd", 1'b0, make_addr(3, 0, 0), '0, 4'hf, 3'b001);
    issue("dec_max_wr", 1'b1, make_addr(2047, 5, 0), draw(), 4'hf, 3'b001);
    issue("dec_max_rd", 1'b0, make_addr(2047, 5, 0), '0, 4'hf, 3'b001);

    // Sweep confirms nothing above touched the banks
    for (s = 0; s < `APB_SLAVE_COUNT; s++) begin
      for (r = 0; r < `APB_REG_COUNT; r++) begin
        issue($sformatf("sweep_s%0d_r%0d", s, r), 1'b0, make_addr(s, r, 0), '0, 4'hf, 3'b000);
      end
    end

    while (rsp_count < cmd_count) @(negedge pclk);
    @(negedge pclk);
    checks += 2;
    assert (xfer_count == exp_xfers[15:0]) else begin
      errors++;
      $display("Error monitor_xfers expected %0d actual %0d", exp_xfers, xfer_count);
    end
    assert (err_count == exp_errs[15:0]) else begin
      errors++;
      $display("Error monitor_errs expected %0d actual %0d", exp_errs, err_count);
    end

    $display("Commands %0d, checks %0d, errors %0d", cmd_count, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- rtl/apb_config.svh
// Bus widths and sizing for the APB subsystem
// Included by the package and by every module that sizes a port from it
// Wait states are fixed per slave here

`ifndef APB_CONFIG_SVH
`define APB_CONFIG_SVH

// Address and data widths
`define APB_ADDR_WIDTH 16
`define APB_DATA_WIDTH 32
`define APB_STRB_WIDTH (`APB_DATA_WIDTH/8)

// Slaves on the shared bus with one psel bit each
`define APB_SLAVE_COUNT 2

// Implemented registers per slave out of 8 addressable slots
`define APB_REG_COUNT 6

// Fixed ACCESS stretch per slave
`define APB_WAIT_STATES_0 0
`define APB_WAIT_STATES_1 2

`endif

//--- rtl/apb_master.sv
// APB3/APB4 bus master driven by a single-command host port
// A cmd_valid pulse while cmd_ready is high starts one transfer
// The slave field picks one psel bit; an absent slave gets a decode error
// rsp_valid pulses once with read data (zero for writes) and the error flag

`timescale 1ns/100ps

`include "apb_config.svh"

module apb_master (
  input  logic                          pclk,
  input  logic                          rst_n,
  // Host command side
  input  logic                          cmd_valid,
  input  logic                          cmd_write,
  input  apb_pkg::apb_addr_t            cmd_addr,
  input  logic [`APB_DATA_WIDTH-1:0]    cmd_wdata,
  input  logic [`APB_STRB_WIDTH-1:0]    cmd_strb,
  input  logic [2:0]                    cmd_prot,
  output logic                          cmd_ready,
  // Host response side
  output logic                          rsp_valid,
  output logic [`APB_DATA_WIDTH-1:0]    rsp_rdata,
  output logic                          rsp_err,
  // APB bus
  output apb_pkg::apb_addr_t            paddr,
  output logic [`APB_SLAVE_COUNT-1:0]   psel,
  output logic                          penable,
  output logic                          pwrite,
  output logic [`APB_DATA_WIDTH-1:0]    pwdata,
  output logic [`APB_STRB_WIDTH-1:0]    pstrb,
  output logic [2:0]                    pprot,
  input  logic [`APB_DATA_WIDTH-1:0]    prdata,
  input  logic                          pready,
  input  logic                          pslverr
);

  import apb_pkg::*;

  apb_state_t                    state_q;
  apb_state_t                    state_d;
  logic                          accept;
  logic                          dec_miss;
  logic [`APB_SLAVE_COUNT-1:0]   sel_dec;

  // Registered command, held for the whole transfer
  apb_addr_t                     addr_r;
  logic                          write_r;
  logic [`APB_DATA_WIDTH-1:0]    wdata_r;
  logic [`APB_STRB_WIDTH-1:0]    strb_r;
  logic [2:0]                    prot_r;
  logic [`APB_SLAVE_COUNT-1:0]   sel_r;
  logic [`APB_DATA_WIDTH-1:0]    rdata_r;
  logic                          err_r;

  assign cmd_ready = (state_q == IDLE);
  assign accept    = cmd_ready & cmd_valid;

  // Slave decode straight off the incoming command
  always_comb begin
    for (int i = 0; i < `APB_SLAVE_COUNT; i++) begin
      sel_dec[i] = (cmd_addr.fields.slave_idx == i);
    end
  end
  assign dec_miss = (cmd_addr.fields.slave_idx >= `APB_SLAVE_COUNT);

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = dec_miss ? RESP : SETUP;
      SETUP:   state_d = ACCESS;
      // Held here while the slave stretches with pready low
      ACCESS:  if (pready) state_d = RESP;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Command capture on accept
  always_ff @(posedge pclk) begin
    if (accept) begin
      addr_r  <= cmd_addr;
      write_r <= cmd_write;
      wdata_r <= cmd_wdata;
      strb_r  <= cmd_strb;
      prot_r  <= cmd_prot;
      sel_r   <= sel_dec;
    end
  end

  // Response capture
  // Decode miss answers at once, bus response on the last ACCESS cycle
  always_ff @(posedge pclk) begin
    if (accept && dec_miss) begin
      rdata_r <= '0;
      err_r   <= 1'b1;
    end else if (state_q == ACCESS && pready) begin
      rdata_r <= write_r ? '0 : prdata;
      err_r   <= pslverr;
    end
  end

  assign rsp_valid = (state_q == RESP);
  assign rsp_rdata = rdata_r;
  assign rsp_err   = err_r;

  // Bus drive, psel only during SETUP and ACCESS
  assign psel    = (state_q == SETUP || state_q == ACCESS) ? sel_r : '0;
  assign penable = (state_q == ACCESS);
  assign paddr   = addr_r;
  assign pwrite  = write_r;
  assign pwdata  = wdata_r;
  // APB4 wants strobes low on reads
  assign pstrb   = write_r ? strb_r : '0;
  assign pprot   = prot_r;

endmodule

//--- rtl/apb_monitor.sv
// Passive APB observer
// Counts completed transfers and the ones that ended with pslverr
// A transfer completes on a cycle with any psel bit, penable and pready high
// Both counters saturate at all ones

`timescale 1ns/100ps

`include "apb_config.svh"

module apb_monitor (
  input  logic                          pclk,
  input  logic                          rst_n,
  input  logic [`APB_SLAVE_COUNT-1:0]   psel,
  input  logic                          penable,
  input  logic                          pready,
  input  logic                          pslverr,
  output logic [15:0]                   xfer_count,
  output logic [15:0]                   err_count
);

  logic any_sel;
  logic xfer_done;
  logic err_done;

  // Collapse the one-hot select to a single bus-active bit
  assign any_sel   = |psel;
  assign xfer_done = any_sel & penable & pready;
  assign err_done  = xfer_done & pslverr;

  // Transfer counter
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      xfer_count <= '0;
    end else if (xfer_done && xfer_count != 16'hffff) begin
      xfer_count <= xfer_count + 16'd1;
    end
  end

  // Error response counter
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      err_count <= '0;
    end else if (err_done && err_count != 16'hffff) begin
      err_count <= err_count + 16'd1;
    end
  end

endmodule

//--- rtl/apb_pkg.sv
// Shared types for the APB subsystem
// Holds the address word views and the master state encoding
// Compile before any module that refers to it

`include "apb_config.svh"

package apb_pkg;

  // Field view of the 16-bit address word
  // Slave field on top, register index, then byte offset
  typedef struct packed {
    logic [10:0] slave_idx;
    logic [2:0]  reg_idx;
    logic [1:0]  byte_off;
  } apb_addr_fields_t;

  // One address word seen two ways
  // Master reads slave_idx, slaves read reg_idx
  typedef union packed {
    logic [`APB_ADDR_WIDTH-1:0] raw;
    apb_addr_fields_t           fields;
  } apb_addr_t;

  // Master FSM encoding
  // RESP is reached from ACCESS or straight from IDLE on a decode miss
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2,
    RESP   = 2'd3
  } apb_state_t;

endpackage

//--- rtl/apb_reg_slave.sv
// APB register-bank slave with byte strobes and fixed wait states
// Holds APB_REG_COUNT words; the upper slots of the index answer pslverr
// Register 0 accepts privileged writes only (pprot bit 0 set)
// WAIT_STATES sets how many ACCESS cycles pready stays low

`timescale 1ns/100ps

`include "apb_config.svh"

module apb_reg_slave #(
  parameter int WAIT_STATES = 0
) (
  input  logic                          pclk,
  input  logic                          rst_n,
  input  logic                          psel,
  input  logic                          penable,
  input  apb_pkg::apb_addr_t            paddr,
  input  logic                          pwrite,
  input  logic [`APB_DATA_WIDTH-1:0]    pwdata,
  input  logic [`APB_STRB_WIDTH-1:0]    pstrb,
  input  logic [2:0]                    pprot,
  output logic [`APB_DATA_WIDTH-1:0]    prdata,
  output logic                          pready,
  output logic                          pslverr
);

  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [`APB_DATA_WIDTH-1:0] regs [`APB_REG_COUNT];
  logic [CNT_W-1:0]           wait_cnt;
  logic                       access;
  logic                       idx_ok;
  logic                       prot_err;
  logic                       err;
  logic                       do_write;

  assign access = psel & penable;

  // Wait counter runs only in ACCESS and restarts for the next transfer
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (!access || pready) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign pready = (wait_cnt == CNT_W'(WAIT_STATES));

  // Error decode
  assign idx_ok   = (paddr.fields.reg_idx < `APB_REG_COUNT);
  // Unprivileged write to the protected register
  assign prot_err = pwrite & (paddr.fields.reg_idx == 3'd0) & ~pprot[0];
  assign err      = ~idx_ok | prot_err;

  assign pslverr  = access & err;
  assign do_write = access & pready & pwrite & ~err;

  // Read path, zero for missing registers and for writes
  assign prdata = (idx_ok && !pwrite) ? regs[paddr.fields.reg_idx] : '0;

  // Byte-merged write on the completing cycle
  always_ff @(posedge pclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `APB_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (do_write) begin
      for (int b = 0; b < `APB_STRB_WIDTH; b++) begin
        if (pstrb[b]) begin
          regs[paddr.fields.reg_idx][b*8 +: 8] <= pwdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

//--- rtl/apb_subsystem.sv
// APB subsystem top level
// One master, two register-bank slaves and a bus monitor on a shared bus
// Host drives single commands on the cmd_* port and gets rsp_* back
// Monitor counters are visible on xfer_count and err_count

`timescale 1ns/100ps

`include "apb_config.svh"

module apb_subsystem (
  input  logic                          pclk,
  input  logic                          rst_n,
  input  logic                          cmd_valid,
  input  logic                          cmd_write,
  input  logic [`APB_ADDR_WIDTH-1:0]    cmd_addr,
  input  logic [`APB_DATA_WIDTH-1:0]    cmd_wdata,
  input  logic [`APB_STRB_WIDTH-1:0]    cmd_strb,
  input  logic [2:0]                    cmd_prot,
  output logic                          cmd_ready,
  output logic                          rsp_valid,
  output logic [`APB_DATA_WIDTH-1:0]    rsp_rdata,
  output logic                          rsp_err,
  output logic [15:0]                   xfer_count,
  output logic [15:0]                   err_count
);

  import apb_pkg::*;

  // Shared bus, master side
  apb_addr_t                     paddr;
  logic [`APB_SLAVE_COUNT-1:0]   psel;
  logic                          penable;
  logic                          pwrite;
  logic [`APB_DATA_WIDTH-1:0]    pwdata;
  logic [`APB_STRB_WIDTH-1:0]    pstrb;
  logic [2:0]                    pprot;

  // Per-slave returns and the muxed result
  logic [`APB_DATA_WIDTH-1:0]    s_prdata  [`APB_SLAVE_COUNT];
  logic                          s_pready  [`APB_SLAVE_COUNT];
  logic                          s_pslverr [`APB_SLAVE_COUNT];
  logic [`APB_DATA_WIDTH-1:0]    prdata;
  logic                          pready;
  logic                          pslverr;

  apb_master i_apb_master (
    .pclk      (pclk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_write (cmd_write),
    .cmd_addr  (cmd_addr),
    .cmd_wdata (cmd_wdata),
    .cmd_strb  (cmd_strb),
    .cmd_prot  (cmd_prot),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .rsp_err   (rsp_err),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .pstrb     (pstrb),
    .pprot     (pprot),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  // Slave 0, no wait states by default
  apb_reg_slave #(.WAIT_STATES(`APB_WAIT_STATES_0)) i_apb_reg_slave_0 (
    .pclk    (pclk),
    .rst_n   (rst_n),
    .psel    (psel[0]),
    .penable (penable),
    .paddr   (paddr),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .pprot   (pprot),
    .prdata  (s_prdata[0]),
    .pready  (s_pready[0]),
    .pslverr (s_pslverr[0])
  );

  // Slave 1, stretched ACCESS
  apb_reg_slave #(.WAIT_STATES(`APB_WAIT_STATES_1)) i_apb_reg_slave_1 (
    .pclk    (pclk),
    .rst_n   (rst_n),
    .psel    (psel[1]),
    .penable (penable),
    .paddr   (paddr),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .pprot   (pprot),
    .prdata  (s_prdata[1]),
    .pready  (s_pready[1]),
    .pslverr (s_pslverr[1])
  );

  // Return mux by psel, idle bus reads zero and ready
  always_comb begin
    prdata  = '0;
    pready  = 1'b1;
    pslverr = 1'b0;
    for (int i = 0; i < `APB_SLAVE_COUNT; i++) begin
      if (psel[i]) begin
        prdata  = s_prdata[i];
        pready  = s_pready[i];
        pslverr = s_pslverr[i];
      end
    end
  end

  // Monitor sees the bus after the mux
  apb_monitor i_apb_monitor (
    .pclk       (pclk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .pslverr    (pslverr),
    .xfer_count (xfer_count),
    .err_count  (err_count)
  );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the APB subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_apb_subsystem -o sim_tb; then
  echo "Verilator compile failed"
  exit 1
fi

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error status"
  exit 1
fi

cat sim.log
if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0
